// ==== rtl/issue_pkg.sv ====
`default_nettype none

package issue_pkg;

    // slot counts per functional-unit class
    localparam int num_fu_alu  = 2;
    localparam int num_fu_mult = 1;
    localparam int num_fu_ld   = 1;
    localparam int num_fu_st   = 1;
    localparam int num_fu_br   = 1;

    localparam int num_fu = num_fu_alu + num_fu_mult + num_fu_ld + num_fu_st + num_fu_br;

    // first flattened slot of each class
    // order is alu, mult, load, store, branch
    localparam int alu_base  = 0;
    localparam int mult_base = alu_base + num_fu_alu;
    localparam int ld_base   = mult_base + num_fu_mult;
    localparam int st_base   = ld_base + num_fu_ld;
    localparam int br_base   = st_base + num_fu_st;

    localparam int num_phys_regs  = 64;
    localparam int phys_reg_idx_w = $clog2(num_phys_regs);
    localparam int data_w         = 32;

    typedef logic [phys_reg_idx_w-1:0] phys_reg_idx_t;
    typedef logic [data_w-1:0]         data_t;

    // alu, mult and branch decode of the instruction word
    typedef struct packed {
        logic [3:0]  spare;
        logic [3:0]  op;
        logic [11:0] imm;
    } alu_fields_t;

    // load and store decode of the same word
    typedef struct packed {
        logic [3:0]  spare;
        logic [1:0]  size;
        logic        sign_ext;
        logic [12:0] offset;
    } mem_fields_t;

    typedef union packed {
        alu_fields_t alu;
        mem_fields_t mem;
    } instr_fields_u;

    // instruction as offered by a reservation station
    typedef struct packed {
        logic          valid;
        phys_reg_idx_t dest_tag;
        phys_reg_idx_t src1;
        phys_reg_idx_t src2;
        instr_fields_u instr;
    } rs_packet_t;

    // issued instruction with its operand values
    typedef struct packed {
        rs_packet_t rs;
        data_t      rs1_value;
        data_t      rs2_value;
    } issue_packet_t;

    // single writeback port
    typedef struct packed {
        logic          valid;
        phys_reg_idx_t idx;
        data_t         data;
    } wb_packet_t;

endpackage

`default_nettype wire

// ==== rtl/phys_regfile.sv ====
`default_nettype none

module phys_regfile
    import issue_pkg::*;
(
    input  logic                         clock,
    input  logic                         reset,

    input  wb_packet_t                   wb,

    input  phys_reg_idx_t [num_fu-1:0]   read_idx_1,
    input  phys_reg_idx_t [num_fu-1:0]   read_idx_2,

    output data_t         [num_fu-1:0]   raw_data_1,
    output data_t         [num_fu-1:0]   raw_data_2
);

    data_t regs [num_phys_regs];

    // one write port, visible to reads after the edge
    always_ff @(posedge clock) begin
        if (reset) begin
            for (int r = 0; r < num_phys_regs; r++) begin
                regs[r] <= '0;
            end
        end else if (wb.valid) begin
            regs[wb.idx] <= wb.data;
        end
    end

    // two read ports per slot, straight from the array
    always_comb begin
        for (int i = 0; i < num_fu; i++) begin
            raw_data_1[i] = regs[read_idx_1[i]];
            raw_data_2[i] = regs[read_idx_2[i]];
        end
    end

endmodule

`default_nettype wire

// ==== rtl/operand_bypass.sv ====
`default_nettype none

module operand_bypass
    import issue_pkg::*;
(
    input  logic                         clock,
    input  logic                         reset,

    input  wb_packet_t                   wb,

    input  phys_reg_idx_t [num_fu-1:0]   read_idx_1,
    input  phys_reg_idx_t [num_fu-1:0]   read_idx_2,
    input  data_t         [num_fu-1:0]   raw_data_1,
    input  data_t         [num_fu-1:0]   raw_data_2,

    output data_t         [num_fu-1:0]   operand_1,
    output data_t         [num_fu-1:0]   operand_2
);

    data_t [num_fu-1:0] next_1;
    data_t [num_fu-1:0] next_2;

    // writeback data wins over the stale array value
    function automatic data_t forward(phys_reg_idx_t idx, data_t raw, wb_packet_t w);
        if (w.valid && (w.idx == idx)) begin
            return w.data;
        end
        return raw;
    endfunction

    always_comb begin
        for (int i = 0; i < num_fu; i++) begin
            next_1[i] = forward(read_idx_1[i], raw_data_1[i], wb);
            next_2[i] = forward(read_idx_2[i], raw_data_2[i], wb);
        end
    end

    // lines up with the registered slot packets in issue_stage
    always_ff @(posedge clock) begin
        if (reset) begin
            operand_1 <= '0;
            operand_2 <= '0;
        end else begin
            operand_1 <= next_1;
            operand_2 <= next_2;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/issue_stage.sv ====
`default_nettype none

module issue_stage
    import issue_pkg::*;
(
    input  logic                         clock,
    input  logic                         reset,

    input  rs_packet_t    [num_fu-1:0]   rs_slots,

    input  data_t         [num_fu-1:0]   operand_1,
    input  data_t         [num_fu-1:0]   operand_2,

    output phys_reg_idx_t [num_fu-1:0]   read_idx_1,
    output phys_reg_idx_t [num_fu-1:0]   read_idx_2,

    output logic          [num_fu-1:0]   rd_en,
    output issue_packet_t [num_fu-1:0]   issue_packs
);

    logic       [num_fu-1:0] slot_valid;
    rs_packet_t [num_fu-1:0] slot_reg;

    // merges the registered packet and its operands
    function automatic issue_packet_t build_pack(rs_packet_t p, data_t v1, data_t v2);
        issue_packet_t pack;
        pack.rs           = p;
        pack.rs1_value    = v1;
        pack.rs2_value    = v2;
        return pack;
    endfunction

    // source tags to register file read ports, fixed slot order
    always_comb begin
        read_idx_1 = '0;
        read_idx_2 = '0;
        slot_valid = '0;

        for (int a = 0; a < num_fu_alu; a++) begin
            read_idx_1[alu_base + a] = rs_slots[alu_base + a].src1;
            read_idx_2[alu_base + a] = rs_slots[alu_base + a].src2;
            slot_valid[alu_base + a] = rs_slots[alu_base + a].valid;
        end

        for (int m = 0; m < num_fu_mult; m++) begin
            read_idx_1[mult_base + m] = rs_slots[mult_base + m].src1;
            read_idx_2[mult_base + m] = rs_slots[mult_base + m].src2;
            slot_valid[mult_base + m] = rs_slots[mult_base + m].valid;
        end

        for (int l = 0; l < num_fu_ld; l++) begin
            read_idx_1[ld_base + l] = rs_slots[ld_base + l].src1;
            read_idx_2[ld_base + l] = rs_slots[ld_base + l].src2;
            slot_valid[ld_base + l] = rs_slots[ld_base + l].valid;
        end

        for (int s = 0; s < num_fu_st; s++) begin
            read_idx_1[st_base + s] = rs_slots[st_base + s].src1;
            read_idx_2[st_base + s] = rs_slots[st_base + s].src2;
            slot_valid[st_base + s] = rs_slots[st_base + s].valid;
        end

        for (int b = 0; b < num_fu_br; b++) begin
            read_idx_1[br_base + b] = rs_slots[br_base + b].src1;
            read_idx_2[br_base + b] = rs_slots[br_base + b].src2;
            slot_valid[br_base + b] = rs_slots[br_base + b].valid;
        end
    end

    // no back-pressure, so rd_en is just the delayed valid
    always_ff @(posedge clock) begin
        if (reset) begin
            rd_en <= '0;
        end else begin
            rd_en <= slot_valid;
        end
    end

    // registered slot packets, valid bits low out of reset
    always_ff @(posedge clock) begin
        if (reset) begin
            slot_reg <= '0;
        end else begin
            slot_reg <= rs_slots;
        end
    end

    // each packet keeps its own registered valid bit
    always_comb begin
        for (int a = 0; a < num_fu_alu; a++) begin
            issue_packs[alu_base + a] = build_pack(slot_reg[alu_base + a],
                operand_1[alu_base + a], operand_2[alu_base + a]);
        end

        for (int m = 0; m < num_fu_mult; m++) begin
            issue_packs[mult_base + m] = build_pack(slot_reg[mult_base + m],
                operand_1[mult_base + m], operand_2[mult_base + m]);
        end

        for (int l = 0; l < num_fu_ld; l++) begin
            issue_packs[ld_base + l] = build_pack(slot_reg[ld_base + l],
                operand_1[ld_base + l], operand_2[ld_base + l]);
        end

        for (int s = 0; s < num_fu_st; s++) begin
            issue_packs[st_base + s] = build_pack(slot_reg[st_base + s],
                operand_1[st_base + s], operand_2[st_base + s]);
        end

        for (int b = 0; b < num_fu_br; b++) begin
            issue_packs[br_base + b] = build_pack(slot_reg[br_base + b],
                operand_1[br_base + b], operand_2[br_base + b]);
        end
    end

endmodule

`default_nettype wire

// ==== rtl/issue_top.sv ====
`default_nettype none

module issue_top
    import issue_pkg::*;
(
    input  logic                         clock,
    input  logic                         reset,

    input  rs_packet_t    [num_fu-1:0]   rs_slots,
    input  wb_packet_t                   wb,

    output logic          [num_fu-1:0]   rd_en,
    output issue_packet_t [num_fu-1:0]   issue_packs
);

    // register file read indices, one pair per slot
    phys_reg_idx_t [num_fu-1:0] read_idx_1;
    phys_reg_idx_t [num_fu-1:0] read_idx_2;

    // unregistered array data
    data_t [num_fu-1:0] raw_data_1;
    data_t [num_fu-1:0] raw_data_2;

    // forwarded and registered operands
    data_t [num_fu-1:0] operand_1;
    data_t [num_fu-1:0] operand_2;

    issue_stage issue_stage_inst (
        .clock       (clock),
        .reset       (reset),
        .rs_slots    (rs_slots),
        .operand_1   (operand_1),
        .operand_2   (operand_2),
        .read_idx_1  (read_idx_1),
        .read_idx_2  (read_idx_2),
        .rd_en       (rd_en),
        .issue_packs (issue_packs)
    );

    phys_regfile phys_regfile_inst (
        .clock      (clock),
        .reset      (reset),
        .wb         (wb),
        .read_idx_1 (read_idx_1),
        .read_idx_2 (read_idx_2),
        .raw_data_1 (raw_data_1),
        .raw_data_2 (raw_data_2)
    );

    // covers a write landing in the same cycle as the read
    operand_bypass operand_bypass_inst (
        .clock      (clock),
        .reset      (reset),
        .wb         (wb),
        .read_idx_1 (read_idx_1),
        .read_idx_2 (read_idx_2),
        .raw_data_1 (raw_data_1),
        .raw_data_2 (raw_data_2),
        .operand_1  (operand_1),
        .operand_2  (operand_2)
    );

endmodule

`default_nettype wire

// ==== tests/issue_assertions.sv ====
`default_nettype none

module issue_assertions
    import issue_pkg::*;
(
    input logic                         clock,
    input logic                         reset,
    input rs_packet_t    [num_fu-1:0]   rs_slots,
    input logic          [num_fu-1:0]   rd_en,
    input issue_packet_t [num_fu-1:0]   issue_packs
);

    logic [num_fu-1:0] in_valid;
    logic [num_fu-1:0] pack_valid;

    // failure count per property
    int reset_fails = 0;
    int valid_fails = 0;
    int follow_fails = 0;

    always_comb begin
        for (int i = 0; i < num_fu; i++) begin
            in_valid[i]   = rs_slots[i].valid;
            pack_valid[i] = issue_packs[i].rs.valid;
        end
    end

    // nothing issues in the cycle after reset
    rd_en_cleared: assert property (@(posedge clock) reset |=> rd_en == '0)
    else begin
        $error("rd_en not zero in the cycle after reset");
        reset_fails++;
    end

    rd_en_matches_valid: assert property (
        @(posedge clock) disable iff (reset) rd_en == pack_valid)
    else begin
        $error("rd_en %b differs from packet valid bits %b", rd_en, pack_valid);
        valid_fails++;
    end

    // one cycle from slot valid to rd_en
    rd_en_follows_slot: assert property (
        @(posedge clock) disable iff (reset) 1'b1 |=> rd_en == $past(in_valid))
    else begin
        $error("rd_en %b does not follow the slot valid bits", rd_en);
        follow_fails++;
    end

endmodule

bind issue_stage issue_assertions issue_assertions_inst (
    .clock       (clock),
    .reset       (reset),
    .rs_slots    (rs_slots),
    .rd_en       (rd_en),
    .issue_packs (issue_packs)
);

`default_nettype wire

// ==== tests/issue_tb.sv ====
`default_nettype none

module issue_tb
    import issue_pkg::*;
();

    localparam int num_rows = 76;

    logic                         clock;
    logic                         reset;
    rs_packet_t    [num_fu-1:0]   rs_slots;
    wb_packet_t                   wb;
    logic          [num_fu-1:0]   rd_en;
    issue_packet_t [num_fu-1:0]   issue_packs;

    // stimulus table, one row per cycle
    string                   row_name [num_rows];
    wb_packet_t              wb_tab   [num_rows];
    rs_packet_t [num_fu-1:0] slot_tab [num_rows];

    // operand values expected one cycle after each row
    data_t exp_1 [num_rows][num_fu];
    data_t exp_2 [num_rows][num_fu];

    // reference register contents
    data_t model [num_phys_regs];

    int seed = 66;
    int row_count = 0;
    int errors = 0;
    int checks = 0;
    int assert_fails;

    issue_top issue_top_inst (
        .clock       (clock),
        .reset       (reset),
        .rs_slots    (rs_slots),
        .wb          (wb),
        .rd_en       (rd_en),
        .issue_packs (issue_packs)
    );

    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    task automatic put_row(string name, logic wv, phys_reg_idx_t wi, data_t wd,
                           logic [num_fu-1:0] mask, int base, int step);
        row_name[row_count] = name;
        wb_tab[row_count] = '{valid: wv, idx: wi, data: wd};
        for (int i = 0; i < num_fu; i++) begin
            slot_tab[row_count][i].valid = mask[i];
            slot_tab[row_count][i].dest_tag = phys_reg_idx_t'($random(seed));
            // two tags per slot, spaced by step
            slot_tab[row_count][i].src1 = phys_reg_idx_t'(base + 2 * i * step);
            slot_tab[row_count][i].src2 = phys_reg_idx_t'(base + (2 * i + 1) * step);
            slot_tab[row_count][i].instr = 20'($random(seed));
        end
        row_count++;
    endtask

    task automatic build_table();
        int base;
        phys_reg_idx_t wi;
        data_t wd;
        int r;

        // write every register once, nothing issued yet
        for (int k = 0; k < num_phys_regs; k++) begin
            wd = $random(seed);
            put_row($sformatf("fill_%0d", k), 1'b1, phys_reg_idx_t'(k), wd, '0, 0, 0);
        end

        put_row("read_alu", 1'b0, '0, '0, 6'b000011, 1, 1);
        put_row("read_mult_ld_st_br", 1'b0, '0, '0, 6'b111100, 40, 2);
        put_row("read_all", 1'b0, '0, '0, '1, 10, 3);
        put_row("bypass_same_reg", 1'b1, 6'd20, 32'hcafe_0020, '1, 20, 0);
        put_row("bypass_rewrite", 1'b1, 6'd7, 32'h0bad_f00d, '1, 7, 1);
        put_row("partial_a", 1'b0, '0, '0, 6'b101001, 30, 1);
        put_row("partial_b", 1'b1, 6'd31, 32'h1357_9bdf, 6'b010110, 30, 1);

        // step 5 is odd, so twelve tags never repeat
        for (int k = 0; k < 4; k++) begin
            base = $random(seed) & 63;
            wi = phys_reg_idx_t'($random(seed));
            wd = $random(seed);
            put_row($sformatf("random_%0d", k), 1'b1, wi, wd, '1, base, 5);
        end

        put_row("union_views", 1'b0, '0, '0, '1, 50, 1);
        r = row_count - 1;
        for (int i = 0; i < num_fu; i++) begin
            if (i == ld_base || i == st_base) begin
                slot_tab[r][i].instr.mem.spare = 4'h0;
                slot_tab[r][i].instr.mem.size = 2'(i);
                slot_tab[r][i].instr.mem.sign_ext = (i == ld_base);
                slot_tab[r][i].instr.mem.offset = 13'h1a00 + 13'(i);
            end else begin
                slot_tab[r][i].instr.alu.spare = 4'h0;
                slot_tab[r][i].instr.alu.op = 4'(i + 1);
                slot_tab[r][i].instr.alu.imm = 12'h800 + 12'(i);
            end
        end

        if (row_count != num_rows) begin
            errors++;
            $display("table has %0d rows but %0d were expected", row_count, num_rows);
        end

        // write first, so a same-row write reaches the operands
        for (int k = 0; k < num_phys_regs; k++) begin
            model[k] = '0;
        end
        for (int k = 0; k < num_rows; k++) begin
            if (wb_tab[k].valid) begin
                model[wb_tab[k].idx] = wb_tab[k].data;
            end
            for (int i = 0; i < num_fu; i++) begin
                exp_1[k][i] = model[slot_tab[k][i].src1];
                exp_2[k][i] = model[slot_tab[k][i].src2];
            end
        end
    endtask

    task automatic check_row(int r);
        logic [num_fu-1:0] mask;
        rs_packet_t want;

        for (int i = 0; i < num_fu; i++) begin
            mask[i] = slot_tab[r][i].valid;
        end
        checks++;
        if (rd_en !== mask) begin
            errors++;
            $display("ERROR %s rd_en: expected %b, actual %b", row_name[r], mask, rd_en);
        end
        for (int i = 0; i < num_fu; i++) begin
            want = slot_tab[r][i];
            checks++;
            if (issue_packs[i].rs.valid !== mask[i]) begin
                errors++;
                $display("ERROR %s slot %0d valid: expected %b, actual %b", row_name[r], i,
                    mask[i], issue_packs[i].rs.valid);
            end
            if (mask[i]) begin
                checks += 4;
                if (issue_packs[i].rs !== want) begin
                    errors++;
                    $display("ERROR %s slot %0d packet: expected %h, actual %h", row_name[r], i,
                        want, issue_packs[i].rs);
                end
                // load and store read the mem view, the rest the alu view
                if (i == ld_base || i == st_base) begin
                    if ({issue_packs[i].rs.instr.mem.size, issue_packs[i].rs.instr.mem.offset}
                        !== {want.instr.mem.size, want.instr.mem.offset}) begin
                        errors++;
                        $display("ERROR %s slot %0d mem fields: expected %h, actual %h",
                            row_name[r], i, {want.instr.mem.size, want.instr.mem.offset},
                            {issue_packs[i].rs.instr.mem.size, issue_packs[i].rs.instr.mem.offset});
                    end
                end else if ({issue_packs[i].rs.instr.alu.op, issue_packs[i].rs.instr.alu.imm}
                    !== {want.instr.alu.op, want.instr.alu.imm}) begin
                    errors++;
                    $display("ERROR %s slot %0d alu fields: expected %h, actual %h",
                        row_name[r], i, {want.instr.alu.op, want.instr.alu.imm},
                        {issue_packs[i].rs.instr.alu.op, issue_packs[i].rs.instr.alu.imm});
                end
                if (issue_packs[i].rs1_value !== exp_1[r][i]) begin
                    errors++;
                    $display("ERROR %s slot %0d rs1_value: expected %h, actual %h", row_name[r],
                        i, exp_1[r][i], issue_packs[i].rs1_value);
                end
                if (issue_packs[i].rs2_value !== exp_2[r][i]) begin
                    errors++;
                    $display("ERROR %s slot %0d rs2_value: expected %h, actual %h", row_name[r],
                        i, exp_2[r][i], issue_packs[i].rs2_value);
                end
            end
        end
    endtask

    initial begin
        reset = 1'b1;
        rs_slots = '0;
        wb = '0;
        build_table();

        repeat (4) @(posedge clock);
        #2;
        reset = 1'b0;

        // idle cycle straight out of reset
        @(posedge clock);
        #2;
        checks++;
        if (rd_en !== '0) begin
            errors++;
            $display("ERROR after_reset rd_en: expected %b, actual %b", {num_fu{1'b0}}, rd_en);
        end
        for (int i = 0; i < num_fu; i++) begin
            checks++;
            if (issue_packs[i].rs.valid !== 1'b0) begin
                errors++;
                $display("ERROR after_reset slot %0d valid: expected 0, actual %b", i,
                    issue_packs[i].rs.valid);
            end
        end

        for (int r = 0; r < num_rows; r++) begin
            rs_slots = slot_tab[r];
            wb = wb_tab[r];
            @(posedge clock);
            #2;
            check_row(r);
        end
        rs_slots = '0;
        wb = '0;

        assert_fails = issue_top_inst.issue_stage_inst.issue_assertions_inst.reset_fails
            + issue_top_inst.issue_stage_inst.issue_assertions_inst.valid_fails
            + issue_top_inst.issue_stage_inst.issue_assertions_inst.follow_fails;
        $display("checks: %0d, errors: %0d, assertion failures: %0d", checks, errors,
            assert_fails);
        if (errors == 0 && assert_fails == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

    // watchdog
    initial begin
        #((num_rows + 20) * 20);
        $display("timeout: the table did not finish in the allowed time");
        $display("CHECKS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== compile.f ====
rtl/issue_pkg.sv
rtl/phys_regfile.sv
rtl/operand_bypass.sv
rtl/issue_stage.sv
rtl/issue_top.sv
tests/issue_assertions.sv
tests/issue_tb.sv

// ==== Makefile ====
# Verilator build and run of the issue stage testbench

TOP     := issue_tb
OBJ_DIR := obj_dir
LOG     := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, search the log for a pass"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --assert --timing -f compile.f --top-module $(TOP) -Mdir $(OBJ_DIR) -o $(TOP)
	./$(OBJ_DIR)/$(TOP) | tee $(LOG)
	@grep -q "ALL CHECKS PASSED" $(LOG) || (echo "simulation did not pass" && exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
